// File: flist.f
+incdir+include
verilog/dma_pkg.sv
verilog/dma_job_dispatch.sv
verilog/dma_channel.sv
verilog/dma_axi_arbiter.sv
verilog/dma_manager.sv
sim/dma_checker.sv
sim/dma_manager_sva.sv
sim/dma_manager_tb.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
TOP        = dma_manager_tb
FLIST      = flist.f
OBJ_DIR    = obj_dir
PASS_MSG   = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: include/dma_job_table.svh
// Job table shared by the testbench and the checker.
// Columns: test, tag, descriptor address, base, word count, error expected.
typedef struct packed {
    logic [2:0]                  test;
    logic [dma_pkg::TAG_W-1:0]   tag;
    logic [dma_pkg::ADDR_W-1:0]  desc_addr;
    logic [dma_pkg::BASE_W-1:0]  base;
    logic [dma_pkg::CNT_W-1:0]   count;
    logic                        err;
} job_row_t;

localparam int          NUM_JOBS    = 15;
localparam int          NUM_TESTS   = 5;
localparam logic [31:0] ERR_LO      = 32'h0000_9000;  // Reads here return SLVERR.
localparam logic [31:0] ERR_HI      = 32'h0000_90ff;
localparam logic [1:0]  RESP_SLVERR = 2'b10;

function automatic job_row_t job_row(input int i);
    job_row_t r;
    r = '0;
    case (i)
        0:  r = '{3'd1, 4'h1, 32'h0100_0000, 24'h00_1000, 8'd1,  1'b0};
        1:  r = '{3'd2, 4'h2, 32'h0100_0010, 24'h00_2000, 8'd6,  1'b0};
        2:  r = '{3'd2, 4'h3, 32'h0100_0020, 24'h00_3000, 8'd3,  1'b0};
        3:  r = '{3'd2, 4'h4, 32'h0100_0030, 24'h00_4000, 8'd8,  1'b0};
        4:  r = '{3'd2, 4'h5, 32'h0100_0040, 24'h00_5000, 8'd5,  1'b0};
        5:  r = '{3'd3, 4'h6, 32'h0100_0050, 24'h00_6000, 8'd12, 1'b0};
        6:  r = '{3'd3, 4'h7, 32'h0100_0060, 24'h00_7000, 8'd20, 1'b0};
        7:  r = '{3'd3, 4'h8, 32'h0100_0070, 24'h00_a000, 8'd7,  1'b0};
        8:  r = '{3'd4, 4'h9, 32'h0100_0080, 24'h00_8ff0, 8'd8,  1'b1};  // Crosses ERR_LO.
        9:  r = '{3'd5, 4'ha, 32'h0100_0090, 24'h00_b000, 8'd4,  1'b0};
        10: r = '{3'd5, 4'hb, 32'h0100_00a0, 24'h00_c000, 8'd9,  1'b0};
        11: r = '{3'd5, 4'hc, 32'h0100_00b0, 24'h00_d000, 8'd2,  1'b0};
        12: r = '{3'd5, 4'hd, 32'h0100_00c0, 24'h00_e000, 8'd6,  1'b0};
        13: r = '{3'd5, 4'he, 32'h0100_00d0, 24'h00_f000, 8'd3,  1'b0};
        14: r = '{3'd5, 4'hf, 32'h0100_00e0, 24'h01_0000, 8'd5,  1'b0};
        default: r = '0;
    endcase
    return r;
endfunction

// Memory contents outside the descriptors.
function automatic logic [31:0] mem_data(input logic [31:0] a);
    return {a[24:0], a[31:25]} ^ 32'h3c5a_0000;
endfunction

function automatic logic in_err_window(input logic [31:0] a);
    return (a >= ERR_LO) && (a <= ERR_HI);
endfunction

// File: sim/dma_manager_tb.sv
`timescale 1ns/1ps

module dma_manager_tb;

    `include "dma_job_table.svh"

    logic                       clk = 1'b0;
    logic                       rst_n;
    dma_pkg::dma_job_t          job;
    logic                       job_valid;
    logic                       job_ready;
    logic [dma_pkg::ADDR_W-1:0] araddr;
    logic [2:0]                 arprot;
    logic                       arvalid;
    logic                       arready;
    logic [dma_pkg::DATA_W-1:0] rdata;
    logic [dma_pkg::RESP_W-1:0] rresp;
    logic                       rvalid;
    logic                       rready;
    dma_pkg::dma_out_t          out;
    logic                       out_valid;
    logic                       fifo_full;

    logic [31:0]                lfsr = 32'h65f7;
    logic                       full_rand = 1'b0;  // Random fifo_full from test 3 on.
    logic [31:0]                ar_q [$];
    int                         tb_errors = 0;
    int                         chk_errors;
    int                         chk_jobs;
    int                         chk_words;

    always #10 clk = ~clk;

    dma_manager #(
        .NUM_CH          (4),
        .MAX_OUTSTANDING (4)
    ) dut0 (.*);

    dma_checker chk0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .out       (out),
        .out_valid (out_valid),
        .fifo_full (fifo_full),
        .errors    (chk_errors),
        .jobs_done (chk_jobs),
        .words     (chk_words)
    );

    // Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1.
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic dma_pkg::dma_rd_rsp_t read_mem(input logic [31:0] a);
        dma_pkg::dma_rd_rsp_t rsp;
        job_row_t             r;
        rsp.data = mem_data(a);
        rsp.resp = dma_pkg::RESP_OKAY;
        if (in_err_window(a)) begin
            rsp.data = '0;
            rsp.resp = RESP_SLVERR;
        end
        for (int i = 0; i < NUM_JOBS; i++) begin
            r = job_row(i);
            if (r.desc_addr == a) begin
                rsp.data = {r.base, r.count};
                rsp.resp = dma_pkg::RESP_OKAY;
            end
        end
        return rsp;
    endfunction

    function automatic int total_words();
        int n;
        n = 0;
        for (int i = 0; i < NUM_JOBS; i++) n += int'(job_row(i).count);
        return n;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1:       return "single word job";
            2:       return "four jobs fill all channels";
            3:       return "random fifo_full";
            4:       return "read error window";
            default: return "more jobs than channels";
        endcase
    endfunction

    // ####################################################################
    // AXI4-Lite memory model and fifo_full
    // ####################################################################

    initial begin
        logic                 ar_take;
        logic                 r_take;
        int                   ff_bit;
        dma_pkg::dma_rd_rsp_t rsp;
        arready   = 1'b0;
        rvalid    = 1'b0;
        rdata     = '0;
        rresp     = '0;
        fifo_full = 1'b0;
        forever begin
            @(negedge clk);
            ar_take = rst_n && arvalid && arready;
            r_take  = rst_n && rvalid && rready;
            if (ar_take) ar_q.push_back(araddr);
            @(posedge clk);
            #2;
            arready = (rand_bits(2) != 0);
            if (r_take) rvalid = 1'b0;
            if (!rvalid && ar_q.size() > 0 && rand_bits(1) != 0) begin
                rsp    = read_mem(ar_q.pop_front());
                rdata  = rsp.data;
                rresp  = rsp.resp;
                rvalid = 1'b1;
            end
            ff_bit    = rand_bits(1);
            fifo_full = full_rand && (ff_bit != 0);
        end
    end

    // ####################################################################
    // Job driver
    // ####################################################################

    task automatic send_job(input job_row_t r);
        job.tag       = r.tag;
        job.desc_addr = r.desc_addr;
        job_valid     = 1'b1;
        while (!job_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);  // Accepted on this edge.
        #2;
        job_valid = 1'b0;
    endtask

    initial begin
        int       target;
        int       err_before;
        job_row_t row;
        target    = 0;
        rst_n     = 1'b0;
        job       = '0;
        job_valid = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        for (int t = 1; t <= NUM_TESTS; t++) begin
            @(negedge clk);
            full_rand  = (t >= 3);
            err_before = chk_errors + tb_errors;
            @(posedge clk);
            #2;
            for (int i = 0; i < NUM_JOBS; i++) begin
                row = job_row(i);
                if (int'(row.test) == t) begin
                    send_job(row);
                    target++;
                end
            end
            if (t == 2) begin
                repeat (2) @(posedge clk);
                #2;
                if (job_ready !== 1'b0) begin
                    tb_errors++;
                    $display("ERROR %0t ns job_ready: expected 0, got %b", $time, job_ready);
                end
            end
            while (chk_jobs < target) @(posedge clk);
            $display("Test %0d (%s): %s", t, test_name(t),
                     (chk_errors + tb_errors == err_before) ? "ok" : "failed");
        end
        repeat (10) @(posedge clk);
        $display("Jobs %0d of %0d, words %0d, errors %0d, assertion failures %0d",
                 chk_jobs, NUM_JOBS, chk_words, chk_errors + tb_errors, dut0.sva0.fails);
        if (chk_errors + tb_errors + dut0.sva0.fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Limit grows with the number of words in the job table.
    initial begin
        int limit;
        int cycles;
        limit  = 200 + 40 * total_words();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d jobs complete",
                 cycles, chk_jobs, NUM_JOBS);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// File: sim/dma_manager_sva.sv
`timescale 1ns/1ps

module dma_manager_sva (
    input logic                       clk,
    input logic                       rst_n,
    input logic [dma_pkg::ADDR_W-1:0] araddr,
    input logic [2:0]                 arprot,
    input logic                       arvalid,
    input logic                       arready,
    input dma_pkg::dma_out_t          out,
    input logic                       out_valid,
    input logic                       fifo_full
);

    int fails = 0;

    ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            fails++;
            $error("araddr or arvalid changed before arready");
        end

    ar_prot: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid |-> !$isunknown(arprot) && $stable(arprot))
        else begin
            fails++;
            $error("arprot is unknown or changed while arvalid was high");
        end

    out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_full && out_valid |=> out_valid && $stable(out))
        else begin
            fails++;
            $error("out changed while fifo_full was high");
        end

    valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid))
        else begin
            fails++;
            $error("out_valid is unknown after reset");
        end

endmodule

bind dma_manager dma_manager_sva sva0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .araddr    (araddr),
    .arprot    (arprot),
    .arvalid   (arvalid),
    .arready   (arready),
    .out       (out),
    .out_valid (out_valid),
    .fifo_full (fifo_full)
);

// File: sim/dma_checker.sv
`timescale 1ns/1ps

module dma_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  dma_pkg::dma_out_t out,
    input  logic              out_valid,
    input  logic              fifo_full,
    output int                errors,
    output int                jobs_done,
    output int                words
);

    `include "dma_job_table.svh"

    int                next_idx [NUM_JOBS];
    logic              closed   [NUM_JOBS];
    int                idx;
    job_row_t          row;
    dma_pkg::dma_out_t exp_w;

    // Expected word k of a job up to the first address in the error window.
    function automatic dma_pkg::dma_out_t expect_word(input job_row_t r, input int k);
        dma_pkg::dma_out_t w;
        logic [31:0]       a;
        a      = 32'(r.base) + 32'(4 * k);
        w.tag  = r.tag;
        w.err  = in_err_window(a);
        w.last = w.err || (k == int'(r.count) - 1);
        w.data = w.err ? a : mem_data(a);
        return w;
    endfunction

    function automatic int find_row(input logic [dma_pkg::TAG_W-1:0] tag);
        int hit;
        hit = -1;
        for (int i = 0; i < NUM_JOBS; i++) begin
            if (job_row(i).tag == tag) hit = i;
        end
        return hit;
    endfunction

    initial begin
        errors    = 0;
        jobs_done = 0;
        words     = 0;
        for (int i = 0; i < NUM_JOBS; i++) begin
            next_idx[i] = 0;
            closed[i]   = 1'b0;
        end
        forever begin
            @(negedge clk);  // Transfer happens at the next rising edge.
            if (rst_n && out_valid === 1'b1 && fifo_full === 1'b0) begin
                words++;
                idx = find_row(out.tag);
                if (idx < 0) begin
                    errors++;
                    $display("%0t ns: output word carries unknown tag %0h", $time, out.tag);
                end else if (closed[idx]) begin
                    errors++;
                    $display("%0t ns: extra word for tag %0h after its last word",
                             $time, out.tag);
                end else begin
                    row   = job_row(idx);
                    exp_w = expect_word(row, next_idx[idx]);
                    if (out !== exp_w) begin
                        errors++;
                        $display("ERROR %0t ns out (tag %0h word %0d): expected %h, got %h",
                                 $time, row.tag, next_idx[idx], exp_w, out);
                    end
                    next_idx[idx]++;
                    if (exp_w.last) begin
                        closed[idx] = 1'b1;
                        jobs_done++;
                        if (out.err !== row.err) begin
                            errors++;
                            $display("ERROR %0t ns out.err (tag %0h): expected %b, got %b",
                                     $time, row.tag, row.err, out.err);
                        end
                        $display("Job tag %0h done at %0t ns, %0d of %0d words%s",
                                 row.tag, $time, next_idx[idx], row.count,
                                 exp_w.err ? ", ended by read error" : "");
                    end
                end
            end
        end
    end

endmodule

// File: verilog/dma_manager.sv
`timescale 1ns/1ps

module dma_manager #(
    parameter int NUM_CH          = 4,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  dma_pkg::dma_job_t          job,
    input  logic                       job_valid,
    output logic                       job_ready,
    output logic [dma_pkg::ADDR_W-1:0] araddr,
    output logic [2:0]                 arprot,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [dma_pkg::DATA_W-1:0] rdata,
    input  logic [dma_pkg::RESP_W-1:0] rresp,
    input  logic                       rvalid,
    output logic                       rready,
    output dma_pkg::dma_out_t          out,
    output logic                       out_valid,
    input  logic                       fifo_full
);

    logic [NUM_CH-1:0]                 idle;
    logic [NUM_CH-1:0]                 start;
    dma_pkg::dma_job_t                 ch_job;
    dma_pkg::dma_rd_req_t [NUM_CH-1:0] rd_req;
    logic [NUM_CH-1:0]                 rd_valid;
    logic [NUM_CH-1:0]                 rd_ready;
    dma_pkg::dma_rd_rsp_t              rd_rsp;
    logic [NUM_CH-1:0]                 rsp_valid;
    dma_pkg::dma_out_t [NUM_CH-1:0]    ch_out;
    logic [NUM_CH-1:0]                 ch_valid;
    logic [NUM_CH-1:0]                 ch_ready;

    dma_job_dispatch #(
        .NUM_CH (NUM_CH)
    ) dispatch0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .job       (job),
        .job_valid (job_valid),
        .job_ready (job_ready),
        .idle      (idle),
        .start     (start),
        .ch_job    (ch_job)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        dma_channel ch0 (
            .clk       (clk),
            .rst_n     (rst_n),
            .start     (start[i]),
            .job       (ch_job),
            .idle      (idle[i]),
            .rd_req    (rd_req[i]),
            .rd_valid  (rd_valid[i]),
            .rd_ready  (rd_ready[i]),
            .rd_rsp    (rd_rsp),
            .rsp_valid (rsp_valid[i]),
            .out       (ch_out[i]),
            .out_valid (ch_valid[i]),
            .out_ready (ch_ready[i])
        );
    end

    dma_axi_arbiter #(
        .NUM_CH          (NUM_CH),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) arb0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_req    (rd_req),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_rsp    (rd_rsp),
        .rsp_valid (rsp_valid),
        .ch_out    (ch_out),
        .ch_valid  (ch_valid),
        .ch_ready  (ch_ready),
        .araddr    (araddr),
        .arprot    (arprot),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .out       (out),
        .out_valid (out_valid),
        .fifo_full (fifo_full)
    );

endmodule

// File: verilog/dma_axi_arbiter.sv
`timescale 1ns/1ps

module dma_axi_arbiter #(
    parameter int NUM_CH          = 4,
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  dma_pkg::dma_rd_req_t [NUM_CH-1:0]    rd_req,
    input  logic [NUM_CH-1:0]                    rd_valid,
    output logic [NUM_CH-1:0]                    rd_ready,
    output dma_pkg::dma_rd_rsp_t                 rd_rsp,
    output logic [NUM_CH-1:0]                    rsp_valid,
    input  dma_pkg::dma_out_t [NUM_CH-1:0]       ch_out,
    input  logic [NUM_CH-1:0]                    ch_valid,
    output logic [NUM_CH-1:0]                    ch_ready,
    output logic [dma_pkg::ADDR_W-1:0]           araddr,
    output logic [2:0]                           arprot,
    output logic                                 arvalid,
    input  logic                                 arready,
    input  logic [dma_pkg::DATA_W-1:0]           rdata,
    input  logic [dma_pkg::RESP_W-1:0]           rresp,
    input  logic                                 rvalid,
    output logic                                 rready,
    output dma_pkg::dma_out_t                    out,
    output logic                                 out_valid,
    input  logic                                 fifo_full
);

    localparam int CH_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;
    localparam int PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int CNT_W = $clog2(MAX_OUTSTANDING + 1);
    localparam logic [2:0] AR_PROT = 3'b001;

    // {found, index} of the first request at or after ptr.
    function automatic logic [CH_W:0] rr_pick(input logic [NUM_CH-1:0] req,
                                              input logic [CH_W-1:0]   ptr);
        logic [CH_W:0] res;
        int            idx;
        res = '0;
        for (int k = NUM_CH - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % NUM_CH;
            if (req[idx]) res = {1'b1, CH_W'(idx)};
        end
        return res;
    endfunction

    function automatic logic [CH_W-1:0] rr_next(input logic [CH_W-1:0] cur);
        return (int'(cur) == NUM_CH - 1) ? '0 : cur + 1'b1;
    endfunction

    function automatic logic [PTR_W-1:0] gf_next(input logic [PTR_W-1:0] cur);
        return (int'(cur) == MAX_OUTSTANDING - 1) ? '0 : cur + 1'b1;
    endfunction

    logic [CH_W:0]    ar_pick;
    logic [CH_W:0]    ob_pick;
    logic [CH_W-1:0]  ar_ptr;
    logic [CH_W-1:0]  ob_ptr;
    logic             ar_grant;
    logic             ob_load;
    logic [CH_W-1:0]  gf_mem [MAX_OUTSTANDING];
    logic [PTR_W-1:0] gf_wr;
    logic [PTR_W-1:0] gf_rd;
    logic [CNT_W-1:0] gf_cnt;
    logic             gf_pop;

    // ####################################################################
    // AR grant and grant FIFO
    // ####################################################################

    assign ar_pick  = rr_pick(rd_valid, ar_ptr);
    assign ar_grant = (!arvalid || arready) && ar_pick[CH_W]
                      && (gf_cnt != CNT_W'(MAX_OUTSTANDING));
    assign gf_pop   = rvalid && rready;
    assign rready   = (gf_cnt != '0);
    assign arprot   = AR_PROT;
    assign rd_rsp.data = rdata;
    assign rd_rsp.resp = rresp;

    always_comb begin
        rd_ready  = '0;
        rsp_valid = '0;
        ch_ready  = '0;
        if (ar_grant) rd_ready[ar_pick[CH_W-1:0]] = 1'b1;
        if (gf_pop) rsp_valid[gf_mem[gf_rd]] = 1'b1;  // Oldest grant.
        if (ob_load && ob_pick[CH_W]) ch_ready[ob_pick[CH_W-1:0]] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
            ar_ptr  <= '0;
            gf_wr   <= '0;
            gf_rd   <= '0;
            gf_cnt  <= '0;
        end else begin
            if (!arvalid || arready) arvalid <= ar_grant;
            if (ar_grant) begin
                ar_ptr <= rr_next(ar_pick[CH_W-1:0]);
                gf_wr  <= gf_next(gf_wr);
            end
            if (gf_pop) gf_rd <= gf_next(gf_rd);
            gf_cnt <= gf_cnt + CNT_W'(ar_grant) - CNT_W'(gf_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (ar_grant) begin
            araddr        <= rd_req[ar_pick[CH_W-1:0]].addr;
            gf_mem[gf_wr] <= ar_pick[CH_W-1:0];
        end
    end

    // ####################################################################
    // Output merge
    // ####################################################################

    assign ob_pick = rr_pick(ch_valid, ob_ptr);
    assign ob_load = !fifo_full;  // Held while full.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            ob_ptr    <= '0;
        end else if (ob_load) begin
            out_valid <= ob_pick[CH_W];
            if (ob_pick[CH_W]) ob_ptr <= rr_next(ob_pick[CH_W-1:0]);
        end
    end

    always_ff @(posedge clk) begin
        if (ob_load && ob_pick[CH_W]) begin
            out <= ch_out[ob_pick[CH_W-1:0]];
        end
    end

endmodule

// File: verilog/dma_channel.sv
`timescale 1ns/1ps

module dma_channel (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  dma_pkg::dma_job_t    job,
    output logic                 idle,
    output dma_pkg::dma_rd_req_t rd_req,
    output logic                 rd_valid,
    input  logic                 rd_ready,
    input  dma_pkg::dma_rd_rsp_t rd_rsp,
    input  logic                 rsp_valid,
    output dma_pkg::dma_out_t    out,
    output logic                 out_valid,
    input  logic                 out_ready
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,   // Descriptor read on AR.
        ST_DWAIT,
        ST_READ,    // Data read on AR.
        ST_RWAIT,
        ST_HOLD
    } state_t;

    state_t                      state;
    logic [dma_pkg::ADDR_W-1:0]  addr;
    logic [dma_pkg::CNT_W-1:0]   remain;
    logic [dma_pkg::TAG_W-1:0]   tag;
    dma_pkg::dma_word_u          word;
    dma_pkg::dma_out_t           rsp_word;
    logic                        rsp_ok;

    assign word        = rd_rsp.data;
    assign rsp_ok      = (rd_rsp.resp == dma_pkg::RESP_OKAY);
    assign idle        = (state == ST_IDLE);
    assign rd_valid    = (state == ST_FETCH) || (state == ST_READ);
    assign rd_req.addr = addr;
    assign out_valid   = (state == ST_HOLD);

    // Error word carries the failing address and closes the job.
    always_comb begin
        rsp_word.tag  = tag;
        rsp_word.err  = !rsp_ok;
        rsp_word.last = !rsp_ok || (remain == dma_pkg::CNT_W'(1));
        rsp_word.data = rsp_ok ? word.raw : dma_pkg::DATA_W'(addr);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:  if (start) state <= ST_FETCH;
                ST_FETCH: if (rd_ready) state <= ST_DWAIT;
                ST_DWAIT: if (rsp_valid) state <= rsp_ok ? ST_READ : ST_HOLD;
                ST_READ:  if (rd_ready) state <= ST_RWAIT;
                ST_RWAIT: if (rsp_valid) state <= ST_HOLD;
                ST_HOLD:  if (out_ready) state <= out.last ? ST_IDLE : ST_READ;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (idle && start) begin
            tag  <= job.tag;
            addr <= job.desc_addr;
        end
        if (state == ST_DWAIT && rsp_valid && rsp_ok) begin
            addr   <= dma_pkg::ADDR_W'(word.desc.base);
            remain <= word.desc.count;
        end
        if (rsp_valid && (state == ST_RWAIT || (state == ST_DWAIT && !rsp_ok))) begin
            out <= rsp_word;
        end
        if (out_valid && out_ready) begin
            addr   <= addr + dma_pkg::ADDR_W'(4);  // Next word.
            remain <= remain - 1'b1;
        end
    end

endmodule

// File: verilog/dma_job_dispatch.sv
`timescale 1ns/1ps

module dma_job_dispatch #(
    parameter int NUM_CH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  dma_pkg::dma_job_t job,
    input  logic              job_valid,
    output logic              job_ready,
    input  logic [NUM_CH-1:0] idle,
    output logic [NUM_CH-1:0] start,
    output dma_pkg::dma_job_t ch_job
);

    logic [NUM_CH-1:0] pick;
    logic              accept;

    assign accept = job_valid && job_ready;

    // Lowest-numbered idle channel wins.
    always_comb begin
        pick = '0;
        for (int i = NUM_CH - 1; i >= 0; i--) begin
            if (idle[i]) begin
                pick    = '0;
                pick[i] = 1'b1;
            end
        end
    end

    // A channel that gets start this cycle leaves idle on the next one,
    // so it is masked out of the ready decision right away.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start     <= '0;
            job_ready <= 1'b0;
        end else begin
            start     <= accept ? pick : '0;
            job_ready <= !accept && |(idle & ~start);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ch_job <= job;  // Shared by all channels.
        end
    end

endmodule

// File: verilog/dma_pkg.sv
package dma_pkg;

    // ####################################################################
    // Widths
    // ####################################################################

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int TAG_W  = 4;
    localparam int BASE_W = 24;  // Byte address in the low 16 MB.
    localparam int CNT_W  = 8;   // Word count, 1 to 255.
    localparam int RESP_W = 2;

    localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

    // ####################################################################
    // Job, descriptor and data words
    // ####################################################################

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [ADDR_W-1:0] desc_addr;
    } dma_job_t;

    typedef struct packed {
        logic [BASE_W-1:0] base;
        logic [CNT_W-1:0]  count;
    } dma_desc_t;

    // One read-data word, seen as a descriptor or as payload.
    typedef union packed {
        dma_desc_t         desc;
        logic [DATA_W-1:0] raw;
    } dma_word_u;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } dma_rd_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [RESP_W-1:0] resp;
    } dma_rd_rsp_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic              err;   // Read failed, data is the address.
        logic              last;  // Final word of the job.
        logic [DATA_W-1:0] data;
    } dma_out_t;

endpackage
